//--- global_controller.f
logic/dram_ctrl_pkg.sv
logic/read_order_fifo.sv
logic/bank_command_dispatch.sv
logic/read_return_steer.sv
logic/global_controller.sv
tb/tb_global_controller.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_global_controller \
		-f global_controller.f -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -F -q "Finished with no errors"

clean:
	rm -rf obj_dir

//--- tb/tb_global_controller.sv
// testbench for the dram global controller: routing, back-pressure and in-order returns
module tb_global_controller;

    localparam int ORDER_DEPTH = 16;
    localparam int NB = dram_ctrl_pkg::NUM_BANKS;
    localparam int WAIT_LIMIT = 100;

    logic clk;
    logic rst_n;
    logic command_valid;
    dram_ctrl_pkg::frontend_command_t command;
    logic [dram_ctrl_pkg::WORD_W-1:0] write_data;
    logic controller_ready;
    logic [NB-1:0] bank_ready;
    logic [NB-1:0] bank_cmd_valid;
    dram_ctrl_pkg::bank_cmd_t [NB-1:0] bank_cmd;
    logic [NB-1:0] ret_valid;
    logic [NB-1:0][dram_ctrl_pkg::WORD_W-1:0] ret_data;
    logic [NB-1:0] ret_ren;
    logic read_data_valid;
    logic [dram_ctrl_pkg::WORD_W-1:0] read_data;

    int errors;
    int reads_seen;
    string test_name;
    // banks re-roll ready and return valid every cycle
    logic rand_mode;
    // banks of accepted reads, oldest first
    int exp_q[$];
    logic [NB-1:0] exp_ren;
    logic [dram_ctrl_pkg::WORD_W-1:0] exp_word;

    global_controller #(.ORDER_DEPTH(ORDER_DEPTH)) uut (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_command_valid(command_valid), .i_command(command), .i_write_data(write_data),
        .o_controller_ready(controller_ready),
        .i_bank_ready(bank_ready), .o_bank_cmd_valid(bank_cmd_valid), .o_bank_cmd(bank_cmd),
        .i_ret_valid(ret_valid), .i_ret_data(ret_data), .o_ret_ren(ret_ren),
        .o_read_data_valid(read_data_valid), .o_read_data(read_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;
        end
    end

    // word each bank model returns, tagged with the bank index
    function automatic logic [dram_ctrl_pkg::WORD_W-1:0] bank_word(input int b);
        return 32'hC0DE_0000 + 32'h0000_0101 * 32'(b);
    endfunction

    function automatic void report_mismatch(input string what, input logic [63:0] expected,
                                            input logic [63:0] actual);
        errors++;
        $display("Error in %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    endfunction

    function automatic void report_failure(input string what);
        errors++;
        $display("Failure in %s: %s", test_name, what);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // drivers
    //////////////////////////////////////////////////////////////////////

    // advance to just after the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (rand_mode)
        begin
            bank_ready = NB'($urandom);
            ret_valid  = NB'($urandom);
        end
    endtask

    task automatic load_cmd(input dram_ctrl_pkg::op_e op, input int bank);
        command.cmd.op_type   = op;
        command.cmd.data_type = dram_ctrl_pkg::data_type_e'(2'($urandom_range(2, 0)));
        command.cmd.row_addr  = dram_ctrl_pkg::ROW_BITS'($urandom);
        command.cmd.col_addr  = dram_ctrl_pkg::COL_BITS'($urandom);
        command.bank_addr     = dram_ctrl_pkg::BANK_BITS'(bank);
        write_data            = $urandom;
        command_valid         = 1'b1;
    endtask

    // hold the loaded command until ready, check routing and payload on transfer
    task automatic complete_cmd(output int waited);
        logic accepted;
        dram_ctrl_pkg::bank_cmd_t exp_cmd;
        waited = 0;
        accepted = 1'b0;
        exp_cmd.cmd = command.cmd;
        exp_cmd.write_data = write_data;
        while (!accepted && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            accepted = controller_ready;
            if (accepted && bank_cmd_valid !== (NB'(1) << command.bank_addr))
                report_mismatch("bank_cmd_valid", NB'(1) << command.bank_addr, bank_cmd_valid);
            if (accepted && bank_cmd[command.bank_addr] !== exp_cmd)
                report_mismatch("bank payload", exp_cmd, bank_cmd[command.bank_addr]);
            @(posedge clk);
            if (accepted && command.cmd.op_type == dram_ctrl_pkg::OP_READ)
                exp_q.push_back(int'(command.bank_addr));
            #2;
            if (!accepted)
                waited++;
            if (rand_mode)
            begin
                bank_ready = NB'($urandom);
                ret_valid  = NB'($urandom);
            end
        end
        if (!accepted)
            report_failure("command never accepted by the controller");
    endtask

    task automatic send_cmd(input dram_ctrl_pkg::op_e op, input int bank);
        int waited;
        load_cmd(op, bank);
        complete_cmd(waited);
    endtask

    // wait until every outstanding read has come back
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < WAIT_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() > 0)
            report_failure("outstanding reads never returned");
    endtask

    // return checker, one head bank enabled and data in issue order
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            exp_ren = (exp_q.size() > 0) ? (NB'(1) << exp_q[0]) : '0;
            if (ret_ren !== exp_ren)
                report_mismatch("ret_ren", exp_ren, ret_ren);
            if (read_data_valid === 1'b1 && exp_q.size() == 0)
                report_failure("read data returned with no read outstanding");
            else if (read_data_valid === 1'b1)
            begin
                exp_word = bank_word(exp_q.pop_front());
                if (read_data !== exp_word)
                    report_mismatch("read_data", exp_word, read_data);
                reads_seen++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        test_name = "reset";
        @(negedge clk);
        if ({controller_ready, bank_cmd_valid, ret_ren, read_data_valid} !== '0)
            report_mismatch("outputs", 0, {controller_ready, bank_cmd_valid, ret_ren,
                                           read_data_valid});
        next_cycle();
    endtask

    task automatic test_write_routing();
        int waited;
        test_name = "write_routing";
        bank_ready = '1;
        for (int b = 0; b < NB; b++)
        begin
            load_cmd(dram_ctrl_pkg::OP_WRITE, b);
            complete_cmd(waited);
            if (waited != 0)
                report_mismatch("cycles to ready", 0, waited);
        end
        command_valid = 1'b0;
    endtask

    task automatic test_bank_backpressure();
        int waited;
        test_name = "bank_backpressure";
        bank_ready = 4'b1101;
        load_cmd(dram_ctrl_pkg::OP_WRITE, 1);
        // valid held, ready low while bank 1 stalls
        repeat (3)
        begin
            @(negedge clk);
            if ({controller_ready, bank_cmd_valid} !== 5'b0_0010)
                report_mismatch("ready and valids", 5'b0_0010, {controller_ready, bank_cmd_valid});
            next_cycle();
        end
        bank_ready = '1;
        complete_cmd(waited);
        if (waited != 0)
            report_mismatch("cycles to ready", 0, waited);
        command_valid = 1'b0;
    endtask

    task automatic test_in_order_returns();
        int order[4] = '{2, 0, 3, 2};
        int start;
        test_name = "in_order_returns";
        start = reads_seen;
        bank_ready = '1;
        ret_valid = '0;
        foreach (order[i])
            send_cmd(dram_ctrl_pkg::OP_READ, order[i]);
        command_valid = 1'b0;
        next_cycle();
        // every bank offers data at once
        ret_valid = '1;
        wait_drain();
        ret_valid = '0;
        if (reads_seen - start != 4)
            report_mismatch("reads returned", 4, reads_seen - start);
    endtask

    task automatic test_order_full();
        int waited;
        test_name = "order_full";
        bank_ready = '1;
        ret_valid = '0;
        for (int i = 0; i < ORDER_DEPTH; i++)
            send_cmd(dram_ctrl_pkg::OP_READ, i % NB);
        // full fifo blocks writes and reads alike
        for (int k = 0; k < 2; k++)
        begin
            load_cmd(k == 0 ? dram_ctrl_pkg::OP_WRITE : dram_ctrl_pkg::OP_READ, 1);
            @(negedge clk);
            if ({controller_ready, bank_cmd_valid} !== '0)
                report_mismatch("ready and valids", 0, {controller_ready, bank_cmd_valid});
            next_cycle();
        end
        // head read is bank 0, one return frees a slot
        ret_valid = 4'b0001;
        next_cycle();
        ret_valid = '0;
        complete_cmd(waited);
        if (waited != 0)
            report_mismatch("cycles to ready after pop", 0, waited);
        command_valid = 1'b0;
        ret_valid = '1;
        wait_drain();
        ret_valid = '0;
    endtask

    task automatic test_random_mix();
        test_name = "random_mix";
        rand_mode = 1'b1;
        for (int i = 0; i < 60; i++)
            send_cmd(dram_ctrl_pkg::op_e'(1'($urandom)), int'($urandom_range(NB - 1, 0)));
        command_valid = 1'b0;
        rand_mode = 1'b0;
        ret_valid = '1;
        wait_drain();
        ret_valid = '0;
    endtask

    initial
    begin
        int seed;
        errors = 0;
        reads_seen = 0;
        rand_mode = 1'b0;
        test_name = "startup";
        seed = $urandom(64);
        rst_n = 1'b0;
        command_valid = 1'b0;
        command = '0;
        write_data = '0;
        bank_ready = '0;
        ret_valid = '0;
        for (int b = 0; b < NB; b++)
            ret_data[b] = bank_word(b);
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset();
        test_write_routing();
        test_bank_backpressure();
        test_in_order_returns();
        test_order_full();
        test_random_mix();
        $display("errors: %0d, reads checked: %0d", errors, reads_seen);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- logic/global_controller.sv
// dram global controller: routes host commands to four banks, returns reads in order
module global_controller #(
    // outstanding reads tracked, power of two
    parameter int ORDER_DEPTH = 16
) (
    input  logic                                                i_clk,
    input  logic                                                i_rst_n,

    // host command channel
    input  logic                                                i_command_valid,
    input  dram_ctrl_pkg::frontend_command_t                    i_command,
    input  logic [dram_ctrl_pkg::WORD_W-1:0]                    i_write_data,
    output logic                                                o_controller_ready,

    // bank command channels
    input  logic [dram_ctrl_pkg::NUM_BANKS-1:0]                 i_bank_ready,
    output logic [dram_ctrl_pkg::NUM_BANKS-1:0]                 o_bank_cmd_valid,
    output dram_ctrl_pkg::bank_cmd_t [dram_ctrl_pkg::NUM_BANKS-1:0] o_bank_cmd,

    // bank return channels
    input  logic [dram_ctrl_pkg::NUM_BANKS-1:0]                 i_ret_valid,
    input  logic [dram_ctrl_pkg::NUM_BANKS-1:0][dram_ctrl_pkg::WORD_W-1:0] i_ret_data,
    output logic [dram_ctrl_pkg::NUM_BANKS-1:0]                 o_ret_ren,

    // host read data channel, no back-pressure
    output logic                                                o_read_data_valid,
    output logic [dram_ctrl_pkg::WORD_W-1:0]                    o_read_data
);

    //////////////////////////////////////////////////////////////////////
    // internal nets
    //////////////////////////////////////////////////////////////////////

    // dispatch to fifo
    logic                                order_push;
    logic [dram_ctrl_pkg::BANK_BITS-1:0] order_push_bank;
    // fifo status
    logic                                order_full;
    logic                                order_empty;
    logic [dram_ctrl_pkg::BANK_BITS-1:0] order_head_bank;
    // steering to fifo
    logic                                order_pop;

    //////////////////////////////////////////////////////////////////////
    // command path
    //////////////////////////////////////////////////////////////////////

    // fully combinational, transfer in the valid/ready cycle
    bank_command_dispatch u_dispatch (
        .i_command_valid    (i_command_valid),
        .i_command          (i_command),
        .i_write_data       (i_write_data),
        .o_controller_ready (o_controller_ready),
        .i_bank_ready       (i_bank_ready),
        .o_bank_cmd_valid   (o_bank_cmd_valid),
        .o_bank_cmd         (o_bank_cmd),
        .i_order_full       (order_full),
        .o_order_push       (order_push),
        .o_order_push_bank  (order_push_bank)
    );

    // read issue order, head visible the cycle after push
    read_order_fifo #(
        .ORDER_DEPTH (ORDER_DEPTH)
    ) u_order_fifo (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_push      (order_push),
        .i_push_bank (order_push_bank),
        .i_pop       (order_pop),
        .o_head_bank (order_head_bank),
        .o_empty     (order_empty),
        .o_full      (order_full)
    );

    //////////////////////////////////////////////////////////////////////
    // return path
    //////////////////////////////////////////////////////////////////////

    read_return_steer u_return (
        .i_head_bank       (order_head_bank),
        .i_empty           (order_empty),
        .o_pop             (order_pop),
        .i_ret_valid       (i_ret_valid),
        .i_ret_data        (i_ret_data),
        .o_ret_ren         (o_ret_ren),
        .o_read_data_valid (o_read_data_valid),
        .o_read_data       (o_read_data)
    );

endmodule

//--- logic/read_return_steer.sv
// return steering: pulls returned data from the banks in read issue order
module read_return_steer (
    // read order fifo read side
    input  logic [dram_ctrl_pkg::BANK_BITS-1:0]                 i_head_bank,
    input  logic                                                i_empty,
    output logic                                                o_pop,
    // bank return channels
    input  logic [dram_ctrl_pkg::NUM_BANKS-1:0]                 i_ret_valid,
    input  logic [dram_ctrl_pkg::NUM_BANKS-1:0][dram_ctrl_pkg::WORD_W-1:0] i_ret_data,
    output logic [dram_ctrl_pkg::NUM_BANKS-1:0]                 o_ret_ren,
    // host read data channel
    output logic                                                o_read_data_valid,
    output logic [dram_ctrl_pkg::WORD_W-1:0]                    o_read_data
);

    // per-bank return handshake
    logic [dram_ctrl_pkg::NUM_BANKS-1:0] ret_hs;
    // any bank handed data over
    logic                                ret_any;

    //////////////////////////////////////////////////////////////////////
    // read enable
    //////////////////////////////////////////////////////////////////////

    // only the oldest outstanding read may return
    // other banks keep their data until they reach the head
    always_comb
    begin
        o_ret_ren = '0;
        for (int b = 0; b < dram_ctrl_pkg::NUM_BANKS; b++)
        begin
            if (!i_empty && (i_head_bank == dram_ctrl_pkg::BANK_BITS'(b)))
            begin
                o_ret_ren[b] = 1'b1;
            end
        end
    end

    assign ret_hs  = i_ret_valid & o_ret_ren;
    assign ret_any = |ret_hs;

    //////////////////////////////////////////////////////////////////////
    // host read data
    //////////////////////////////////////////////////////////////////////

    // at most one handshake per cycle, always the head bank
    assign o_pop             = ret_any;
    assign o_read_data_valid = ret_any;

    // head bank word, zero when idle
    always_comb
    begin
        if (ret_any)
        begin
            o_read_data = i_ret_data[i_head_bank];
        end
        else
        begin
            o_read_data = '0;
        end
    end

endmodule

//--- logic/bank_command_dispatch.sv
// command dispatch: host handshake and routing of commands to the bank controllers
module bank_command_dispatch (
    // host command channel
    input  logic                                                i_command_valid,
    input  dram_ctrl_pkg::frontend_command_t                    i_command,
    input  logic [dram_ctrl_pkg::WORD_W-1:0]                    i_write_data,
    output logic                                                o_controller_ready,
    // bank command channels
    input  logic [dram_ctrl_pkg::NUM_BANKS-1:0]                 i_bank_ready,
    output logic [dram_ctrl_pkg::NUM_BANKS-1:0]                 o_bank_cmd_valid,
    output dram_ctrl_pkg::bank_cmd_t [dram_ctrl_pkg::NUM_BANKS-1:0] o_bank_cmd,
    // read order fifo write side
    input  logic                                                i_order_full,
    output logic                                                o_order_push,
    output logic [dram_ctrl_pkg::BANK_BITS-1:0]                 o_order_push_bank
);

    // one-hot of the addressed bank
    logic [dram_ctrl_pkg::NUM_BANKS-1:0] bank_sel;
    // room left to record a read
    logic                                order_space;
    // command handed over this cycle
    logic                                transfer;

    assign order_space = !i_order_full;

    // bank address decode
    always_comb
    begin
        bank_sel = '0;
        bank_sel[i_command.bank_addr] = 1'b1;
    end

    // valid never looks at bank ready
    // full fifo holds back writes too, keeps ordering simple
    assign o_bank_cmd_valid = (i_command_valid && order_space) ? bank_sel : '0;

    // host ready from the addressed bank only
    assign o_controller_ready = i_command_valid && order_space &&
                                i_bank_ready[i_command.bank_addr];

    assign transfer = i_command_valid && o_controller_ready;

    // same payload broadcast to every bank
    always_comb
    begin
        for (int b = 0; b < dram_ctrl_pkg::NUM_BANKS; b++)
        begin
            o_bank_cmd[b].cmd        = i_command.cmd;
            o_bank_cmd[b].write_data = i_write_data;
        end
    end

    // accepted read, remember which bank owes the data
    assign o_order_push      = transfer && (i_command.cmd.op_type == dram_ctrl_pkg::OP_READ);
    assign o_order_push_bank = i_command.bank_addr;

endmodule

//--- logic/read_order_fifo.sv
// read order fifo: keeps bank indices of issued reads in issue order
module read_order_fifo #(
    // entries, power of two and at least 2
    parameter int ORDER_DEPTH = 16
) (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    // write side, from command dispatch
    input  logic                                i_push,
    input  logic [dram_ctrl_pkg::BANK_BITS-1:0] i_push_bank,
    // read side, from return steering
    input  logic                                i_pop,
    output logic [dram_ctrl_pkg::BANK_BITS-1:0] o_head_bank,
    output logic                                o_empty,
    output logic                                o_full
);

    localparam int PTR_W = $clog2(ORDER_DEPTH);
    localparam int CNT_W = $clog2(ORDER_DEPTH + 1);

    // storage
    logic [dram_ctrl_pkg::BANK_BITS-1:0] order_mem [ORDER_DEPTH];

    // pointers wrap by overflow
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // occupancy
    logic [CNT_W-1:0] count;

    // qualified requests
    logic push_ok;
    logic pop_ok;

    // push when full / pop when empty dropped
    assign push_ok = i_push && !o_full;
    assign pop_ok  = i_pop && !o_empty;

    // storage write
    always_ff @(posedge i_clk)
    begin
        if (push_ok)
        begin
            order_mem[wr_ptr] <= i_push_bank;
        end
    end

    // pointer and count update
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_ok)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (push_ok && !pop_ok)
            begin
                count <= count + 1'b1;
            end
            else if (pop_ok && !push_ok)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // head read straight from storage
    assign o_head_bank = order_mem[rd_ptr];
    assign o_empty     = (count == '0);
    assign o_full      = (count == CNT_W'(ORDER_DEPTH));

endmodule

//--- logic/dram_ctrl_pkg.sv
// dram controller package: widths, opcode encodings and command structs
package dram_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    // host and bank data word
    localparam int WORD_W = 32;
    // dram address fields
    localparam int ROW_BITS = 14;
    localparam int COL_BITS = 10;
    localparam int BANK_BITS = 2;
    // one bank controller per bank address
    localparam int NUM_BANKS = 1 << BANK_BITS;
    // opcode field widths
    localparam int OP_BITS = 1;
    localparam int DATA_TYPE_BITS = 2;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [OP_BITS-1:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    // tensor class of the access
    typedef enum logic [DATA_TYPE_BITS-1:0] {
        DATA_TYPE_WEIGHTS     = 2'd0,
        DATA_TYPE_ACTIVATIONS = 2'd1,
        DATA_TYPE_OUTPUTS     = 2'd2
    } data_type_e;

    //////////////////////////////////////////////////////////////////////
    // command structs
    //////////////////////////////////////////////////////////////////////

    // what a bank controller sees, 27 bits
    typedef struct packed {
        op_e                 op_type;
        data_type_e          data_type;
        logic [ROW_BITS-1:0] row_addr;
        logic [COL_BITS-1:0] col_addr;
    } backend_command_t;

    // host command with bank select on top, 29 bits
    typedef struct packed {
        backend_command_t     cmd;
        logic [BANK_BITS-1:0] bank_addr;
    } frontend_command_t;

    // one bank's payload, command plus write word, 59 bits
    typedef struct packed {
        backend_command_t    cmd;
        logic [WORD_W-1:0]   write_data;
    } bank_cmd_t;

endpackage
